//--- all.f
design/exec_pkg.sv
design/cla_32.sv
design/issue_int.sv
design/issue_mult.sv
design/cdb_arbiter.sv
design/issue_dispatch.sv
design/exec_top.sv
testbench/exec_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Compile and run the execution back end testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert -j 0 \
   --top-module exec_tb \
   -f all.f \
   -Mdir "$BUILD_DIR" -o exec_sim
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

"./$BUILD_DIR/exec_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if grep -qx "TESTBENCH PASSED" "$LOG"; then
   exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- testbench/exec_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exec_tb
   import exec_pkg::*;
();

   localparam int N_INSTR = 9*8 + 16 + 4*8 + 8 + 4 + 8 + 8 + 40;
   localparam int LIMIT   = N_INSTR * 40 + 100;

   logic        clk;
   logic        reset;
   logic        issue_req;
   exec_instr_t issue_instr;
   logic        issue_ack;
   cdb_t        cdb;

   exec_result_t         expected [64];
   int                   issued_cnt [64];
   int                   seen_cnt [64];
   logic [TAG_WIDTH-1:0] next_tag;
   string                test_name;
   int                   cycles;
   int                   data_errs;
   int                   flag_errs;
   int                   tag_errs;
   int                   gap_errs;
   int                   reset_errs;
   int                   errs_at_start;
   int                   test_instrs;
   int                   tests_passed;
   int                   tests_failed;

   // Boundary operand pairs, rs then rt
   logic [31:0] corner_a [8] = '{32'h0, 32'h1, 32'h7fffffff, 32'h80000000,
                                 32'h80000000, 32'hffffffff, 32'h12345678, 32'h5};
   logic [31:0] corner_b [8] = '{32'h0, 32'hffffffff, 32'h1, 32'hffffffff,
                                 32'h1, 32'hffffffff, 32'h9abcdef0, 32'h80000000};

   exec_top #(
      .MULT_BITS (2)
   ) UUT (
      .clk         (clk),
      .reset       (reset),
      .issue_req   (issue_req),
      .issue_instr (issue_instr),
      .issue_ack   (issue_ack),
      .cdb         (cdb)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Reference model
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   function automatic exec_result_t model_result(input exec_instr_t ins);
      exec_result_t r;
      logic [32:0]  wide;
      logic [63:0]  prod;
      r = '0;
      r.rd_tag = ins.rd_tag;
      case (ins.op)
         ADD, ADDU: begin
            wide = {1'b0, ins.rs_data} + {1'b0, ins.rt_data};
            r.data = wide[31:0];
            r.carry = wide[32];
            r.overflow = (ins.rs_data[31] == ins.rt_data[31]) && (wide[31] != ins.rs_data[31]);
         end
         SUB, SUBU: begin
            // Two's complement subtract, carry out means no borrow
            wide = {1'b0, ins.rs_data} + {1'b0, ~ins.rt_data} + 33'd1;
            r.data = wide[31:0];
            r.carry = wide[32];
            r.overflow = (ins.rs_data[31] != ins.rt_data[31]) && (wide[31] != ins.rs_data[31]);
         end
         AND:  r.data = ins.rs_data & ins.rt_data;
         OR:   r.data = ins.rs_data | ins.rt_data;
         NOR:  r.data = ~(ins.rs_data | ins.rt_data);
         SLT:  r.data = ($signed(ins.rs_data) < $signed(ins.rt_data)) ? 32'd1 : 32'd0;
         SLTU: r.data = (ins.rs_data < ins.rt_data) ? 32'd1 : 32'd0;
         BEQ: begin
            r.is_branch = 1'b1;
            r.branch_taken = (ins.rs_data == ins.rt_data);
         end
         MULT: begin
            prod = {32'd0, ins.rs_data} * {32'd0, ins.rt_data};
            r.data = prod[31:0];
         end
         default: ;
      endcase
      return r;
   endfunction

   function automatic int error_total();
      return data_errs + flag_errs + tag_errs + gap_errs + reset_errs;
   endfunction

   function automatic exec_op_e rand_op(input int top);
      return exec_op_e'(4'($urandom_range(top)));
   endfunction

   // Edge values about a third of the time
   function automatic logic [31:0] rand_operand();
      case ($urandom_range(14))
         0: return 32'h0;
         1: return 32'h1;
         2: return 32'h7fffffff;
         3: return 32'h80000000;
         4: return 32'hffffffff;
         default: return $urandom;
      endcase
   endfunction

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Issue driver and test bookkeeping
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic issue_one(input exec_op_e op, input logic [31:0] a, input logic [31:0] b);
      exec_instr_t ins;
      ins.op = op;
      ins.rs_data = a;
      ins.rt_data = b;
      ins.rd_tag = next_tag;
      while (issued_cnt[next_tag] != seen_cnt[next_tag])
         @(posedge clk);
      expected[next_tag] = model_result(ins);
      issued_cnt[next_tag] = issued_cnt[next_tag] + 1;
      @(posedge clk);
      issue_instr <= ins;
      issue_req   <= 1'b1;
      do @(posedge clk); while (!issue_ack);
      issue_req <= 1'b0;
      do @(posedge clk); while (issue_ack);
      next_tag = next_tag + 6'd1;
      test_instrs++;
   endtask

   task automatic wait_drained();
      for (int t = 0; t < 64; t++) begin
         while (issued_cnt[t] != seen_cnt[t])
            @(posedge clk);
      end
      repeat (3) @(posedge clk);
   endtask

   task automatic begin_test(input string name);
      test_name = name;
      errs_at_start = error_total();
      test_instrs = 0;
   endtask

   task automatic close_test();
      int errs;
      wait_drained();
      errs = error_total() - errs_at_start;
      if (errs == 0)
         tests_passed++;
      else
         tests_failed++;
      $display("Test %-12s %s  instructions %0d  errors %0d", test_name,
               (errs == 0) ? "passed" : "failed", test_instrs, errs);
   endtask

   always @(posedge clk) begin
      if (!reset && cdb.valid)
         seen_cnt[cdb.result.rd_tag] <= seen_cnt[cdb.result.rd_tag] + 1;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= LIMIT) begin
         $display("Timeout after %0d cycles in test %s, a handshake or result never came",
                  cycles, test_name);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Checks on the CDB
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   assert property (@(posedge clk) disable iff (reset)
      cdb.valid |-> cdb.result.data == expected[cdb.result.rd_tag].data)
   else begin
      data_errs++;
      $display("** Error %s tag %0d data: expected %h, actual %h", test_name,
               $sampled(cdb.result.rd_tag), expected[$sampled(cdb.result.rd_tag)].data,
               $sampled(cdb.result.data));
   end

   // Flags as carry, overflow, is_branch, branch_taken
   assert property (@(posedge clk) disable iff (reset)
      cdb.valid |-> cdb.result[3:0] == expected[cdb.result.rd_tag][3:0])
   else begin
      flag_errs++;
      $display("** Error %s tag %0d flags: expected %b, actual %b", test_name,
               $sampled(cdb.result.rd_tag), expected[$sampled(cdb.result.rd_tag)][3:0],
               $sampled(cdb.result[3:0]));
   end

   assert property (@(posedge clk) disable iff (reset)
      cdb.valid |-> issued_cnt[cdb.result.rd_tag] == seen_cnt[cdb.result.rd_tag] + 1)
   else begin
      tag_errs++;
      $display("Test %s: tag %0d was broadcast without a matching issue", test_name,
               $sampled(cdb.result.rd_tag));
   end

   assert property (@(posedge clk) disable iff (reset)
      cdb.valid |=> !cdb.valid)
   else begin
      gap_errs++;
      $display("Test %s: two CDB valid cycles ran together", test_name);
   end

   assert property (@(posedge clk)
      (reset || $fell(reset)) |=> !issue_ack && !cdb.valid)
   else begin
      reset_errs++;
      $display("Test %s: issue_ack or CDB valid high during or right after reset", test_name);
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Test sequence
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   initial begin
      void'($urandom(24));
      reset = 1'b1;
      issue_req = 1'b0;
      issue_instr = '0;
      next_tag = '0;
      begin_test("reset");
      repeat (5) @(posedge clk);
      reset <= 1'b0;
      close_test();

      begin_test("arith_logic");
      for (int k = 0; k <= 8; k++) begin
         for (int p = 0; p < 8; p++)
            issue_one(exec_op_e'(4'(k)), corner_a[p], corner_b[p]);
      end
      repeat (16) issue_one(rand_op(8), rand_operand(), rand_operand());
      close_test();

      begin_test("flags");
      for (int k = 0; k <= 3; k++) begin
         for (int p = 0; p < 8; p++)
            issue_one(exec_op_e'(4'(k)), corner_b[p], corner_a[p]);
      end
      close_test();

      begin_test("branch");
      for (int p = 0; p < 8; p++)
         issue_one(BEQ, corner_a[p], corner_b[p]);
      for (int i = 0; i < 4; i++) begin
         logic [31:0] v;
         v = rand_operand();
         issue_one(BEQ, v, v);
      end
      close_test();

      begin_test("multiply");
      for (int p = 0; p < 8; p++)
         issue_one(MULT, corner_a[p], corner_b[p]);
      repeat (8) issue_one(MULT, rand_operand(), rand_operand());
      close_test();

      // MULT then ALU with a gap that grows each round, so the ALU result
      // sweeps across the multiplier result at the arbiter
      begin_test("contention");
      for (int i = 0; i < 20; i++) begin
         issue_one(MULT, rand_operand(), rand_operand());
         repeat (i) @(posedge clk);
         issue_one(rand_op(9), rand_operand(), rand_operand());
      end
      close_test();

      $display("Tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed,
               error_total());
      if (tests_failed == 0 && error_total() == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- design/exec_top.sv
`timescale 1ns/1ps
`default_nettype none

module exec_top
   import exec_pkg::*;
#(
   parameter int MULT_BITS = 2
) (
   input  logic        clk,
   input  logic        reset,
   input  logic        issue_req,
   input  exec_instr_t issue_instr,
   output logic        issue_ack,
   output cdb_t        cdb
);

   logic         int_req;
   logic         int_ack;
   exec_instr_t  int_instr;
   logic         mul_req;
   logic         mul_ack;
   exec_instr_t  mul_instr;
   logic         int_res_req;
   logic         int_res_ack;
   exec_result_t int_res;
   logic         mul_res_req;
   logic         mul_res_ack;
   exec_result_t mul_res;

   issue_dispatch u_dispatch (
      .clk         (clk),
      .reset       (reset),
      .issue_req   (issue_req),
      .issue_instr (issue_instr),
      .issue_ack   (issue_ack),
      .int_req     (int_req),
      .int_instr   (int_instr),
      .int_ack     (int_ack),
      .mul_req     (mul_req),
      .mul_instr   (mul_instr),
      .mul_ack     (mul_ack)
   );

   issue_int u_int (
      .clk         (clk),
      .reset       (reset),
      .int_req     (int_req),
      .int_instr   (int_instr),
      .int_ack     (int_ack),
      .int_res_req (int_res_req),
      .int_res     (int_res),
      .int_res_ack (int_res_ack)
   );

   issue_mult #(
      .MULT_BITS (MULT_BITS)
   ) u_mult (
      .clk         (clk),
      .reset       (reset),
      .mul_req     (mul_req),
      .mul_instr   (mul_instr),
      .mul_ack     (mul_ack),
      .mul_res_req (mul_res_req),
      .mul_res     (mul_res),
      .mul_res_ack (mul_res_ack)
   );

   cdb_arbiter u_arbiter (
      .clk         (clk),
      .reset       (reset),
      .int_res_req (int_res_req),
      .int_res     (int_res),
      .int_res_ack (int_res_ack),
      .mul_res_req (mul_res_req),
      .mul_res     (mul_res),
      .mul_res_ack (mul_res_ack),
      .cdb         (cdb)
   );

endmodule

`default_nettype wire

//--- design/issue_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module issue_dispatch
   import exec_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        issue_req,
   input  exec_instr_t issue_instr,
   output logic        issue_ack,
   output logic        int_req,
   output exec_instr_t int_instr,
   input  logic        int_ack,
   output logic        mul_req,
   output exec_instr_t mul_instr,
   input  logic        mul_ack
);

   typedef enum logic [1:0] {
      IDLE,
      FORWARD,
      ACK_UP,
      WAIT_DROP
   } disp_state_e;

   disp_state_e state;
   logic        sel_mul;
   logic        is_mult;
   logic        unit_ack;

   assign is_mult  = (issue_instr.op == MULT);
   assign unit_ack = sel_mul ? mul_ack : int_ack;

   // Source holds the instruction until issue_ack, which covers the unit handshake
   assign int_instr = issue_instr;
   assign mul_instr = issue_instr;

   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= IDLE;
         sel_mul   <= 1'b0;
         issue_ack <= 1'b0;
         int_req   <= 1'b0;
         mul_req   <= 1'b0;
      end else begin
         case (state)
            IDLE: begin
               if (issue_req) begin
                  sel_mul <= is_mult;
                  int_req <= !is_mult;
                  mul_req <= is_mult;
                  state   <= FORWARD;
               end
            end
            // Unit has latched it once ack rises
            FORWARD: begin
               if (unit_ack) begin
                  int_req <= 1'b0;
                  mul_req <= 1'b0;
                  state   <= ACK_UP;
               end
            end
            ACK_UP: begin
               if (!unit_ack) begin
                  issue_ack <= 1'b1;
                  state     <= WAIT_DROP;
               end
            end
            WAIT_DROP: begin
               if (!issue_req) begin
                  issue_ack <= 1'b0;
                  state     <= IDLE;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   assert property (@(posedge clk) disable iff (reset)
      int_req |=> !int_req || $stable(int_instr));

   assert property (@(posedge clk) disable iff (reset)
      mul_req |=> !mul_req || $stable(mul_instr));

endmodule

`default_nettype wire

//--- design/cdb_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module cdb_arbiter
   import exec_pkg::*;
(
   input  logic         clk,
   input  logic         reset,
   input  logic         int_res_req,
   input  exec_result_t int_res,
   output logic         int_res_ack,
   input  logic         mul_res_req,
   input  exec_result_t mul_res,
   output logic         mul_res_ack,
   output cdb_t         cdb
);

   logic         last_mul;
   logic         int_pend;
   logic         mul_pend;
   logic         bus_free;
   logic         grant_int;
   logic         grant_mul;
   logic         cdb_valid;
   exec_result_t cdb_result;

   assign int_pend = int_res_req && !int_res_ack;
   assign mul_pend = mul_res_req && !mul_res_ack;

   // One handshake open at a time
   assign bus_free = !int_res_ack && !mul_res_ack;

   // Round robin, the unit not served last wins a tie
   assign grant_int = bus_free && int_pend && (!mul_pend || last_mul);
   assign grant_mul = bus_free && mul_pend && !grant_int;

   always_ff @(posedge clk) begin
      if (reset) begin
         last_mul    <= 1'b0;
         int_res_ack <= 1'b0;
         mul_res_ack <= 1'b0;
         cdb_valid   <= 1'b0;
      end else begin
         cdb_valid <= grant_int || grant_mul;

         if (grant_int) begin
            int_res_ack <= 1'b1;
            last_mul    <= 1'b0;
         end else if (int_res_ack && !int_res_req) begin
            int_res_ack <= 1'b0;
         end

         if (grant_mul) begin
            mul_res_ack <= 1'b1;
            last_mul    <= 1'b1;
         end else if (mul_res_ack && !mul_res_req) begin
            mul_res_ack <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (grant_int)
         cdb_result <= int_res;
      else if (grant_mul)
         cdb_result <= mul_res;
   end

   assign cdb = '{valid: cdb_valid, result: cdb_result};

   assert property (@(posedge clk) disable iff (reset)
      !(int_res_ack && mul_res_ack));

   // Each grant broadcasts once
   assert property (@(posedge clk) disable iff (reset)
      cdb_valid |=> !cdb_valid);

endmodule

`default_nettype wire

//--- design/issue_mult.sv
`timescale 1ns/1ps
`default_nettype none

module issue_mult
   import exec_pkg::*;
#(
   parameter int MULT_BITS = 2
) (
   input  logic         clk,
   input  logic         reset,
   input  logic         mul_req,
   input  exec_instr_t  mul_instr,
   output logic         mul_ack,
   output logic         mul_res_req,
   output exec_result_t mul_res,
   input  logic         mul_res_ack
);

   localparam int STEPS = DATA_WIDTH / MULT_BITS;
   localparam int CNT_W = $clog2(STEPS + 1);

   typedef enum logic [1:0] {
      IDLE,
      BUSY,
      REPORT
   } mul_state_e;

   mul_state_e            state;
   logic [CNT_W-1:0]      count;
   logic [DATA_WIDTH-1:0] acc;
   logic [DATA_WIDTH-1:0] mcand;
   logic [DATA_WIDTH-1:0] mplier;
   logic [TAG_WIDTH-1:0]  tag;
   logic [DATA_WIDTH-1:0] partial;
   logic                  accept;

   assign accept = (state == IDLE) && mul_req && !mul_ack;

   // Multiplicand multiples for the next MULT_BITS multiplier bits
   always_comb begin
      partial = '0;
      for (int j = 0; j < MULT_BITS; j++) begin
         if (mplier[j])
            partial = partial + (mcand << j);
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state       <= IDLE;
         count       <= '0;
         mul_ack     <= 1'b0;
         mul_res_req <= 1'b0;
      end else begin
         if (mul_ack && !mul_req)
            mul_ack <= 1'b0;
         case (state)
            IDLE: begin
               if (accept) begin
                  mul_ack <= 1'b1;
                  count   <= CNT_W'(STEPS - 1);
                  state   <= BUSY;
               end
            end
            BUSY: begin
               count <= count - CNT_W'(1);
               if (count == '0) begin
                  mul_res_req <= 1'b1;
                  state       <= REPORT;
               end
            end
            REPORT: begin
               if (mul_res_req && mul_res_ack)
                  mul_res_req <= 1'b0;
               else if (!mul_res_req && !mul_res_ack)
                  state <= IDLE;
            end
            default: state <= IDLE;
         endcase
      end
   end

   // Shift-add datapath
   always_ff @(posedge clk) begin
      if (accept) begin
         acc    <= '0;
         mcand  <= mul_instr.rs_data;
         mplier <= mul_instr.rt_data;
         tag    <= mul_instr.rd_tag;
      end else if (state == BUSY) begin
         acc    <= acc + partial;
         mcand  <= mcand << MULT_BITS;
         mplier <= mplier >> MULT_BITS;
      end
   end

   // Low half of the product, no flags
   always_comb begin
      mul_res        = '0;
      mul_res.data   = acc;
      mul_res.rd_tag = tag;
   end

endmodule

`default_nettype wire

//--- design/issue_int.sv
`timescale 1ns/1ps
`default_nettype none

module issue_int
   import exec_pkg::*;
(
   input  logic         clk,
   input  logic         reset,
   input  logic         int_req,
   input  exec_instr_t  int_instr,
   output logic         int_ack,
   output logic         int_res_req,
   output exec_result_t int_res,
   input  logic         int_res_ack
);

   typedef enum logic [1:0] {
      IDLE,
      EXEC,
      REPORT
   } int_state_e;

   int_state_e            state;
   exec_instr_t           instr;
   logic                  accept;
   logic [DATA_WIDTH-1:0] add_b;
   logic                  add_cin;
   logic [DATA_WIDTH-1:0] add_sum;
   logic                  add_cout;
   logic                  add_ovf;

   assign accept = (state == IDLE) && int_req && !int_ack;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Handshakes
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge clk) begin
      if (reset) begin
         state       <= IDLE;
         int_ack     <= 1'b0;
         int_res_req <= 1'b0;
      end else begin
         if (int_ack && !int_req)
            int_ack <= 1'b0;
         case (state)
            IDLE: begin
               if (accept) begin
                  int_ack <= 1'b1;
                  state   <= EXEC;
               end
            end
            EXEC: begin
               int_res_req <= 1'b1;
               state       <= REPORT;
            end
            REPORT: begin
               // Busy until the result ack has dropped again
               if (int_res_req && int_res_ack)
                  int_res_req <= 1'b0;
               else if (!int_res_req && !int_res_ack)
                  state <= IDLE;
            end
            default: state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (accept)
         instr <= int_instr;
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Datapath
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // Subtract as rs + ~rt + 1
   always_comb begin
      add_b   = instr.rt_data;
      add_cin = 1'b0;
      if (instr.op == SUB || instr.op == SUBU) begin
         add_b   = ~instr.rt_data;
         add_cin = 1'b1;
      end
   end

   cla_32 u_cla (
      .a_in      (instr.rs_data),
      .b_in      (add_b),
      .carry_in  (add_cin),
      .sum       (add_sum),
      .carry_out (add_cout),
      .overflow  (add_ovf)
   );

   always_comb begin
      int_res        = '0;
      int_res.rd_tag = instr.rd_tag;
      case (instr.op)
         ADD, ADDU, SUB, SUBU: begin
            int_res.data     = add_sum;
            int_res.carry    = add_cout;
            int_res.overflow = add_ovf;
         end
         AND:  int_res.data = instr.rs_data & instr.rt_data;
         OR:   int_res.data = instr.rs_data | instr.rt_data;
         NOR:  int_res.data = ~(instr.rs_data | instr.rt_data);
         SLT: begin
            int_res.data = {{(DATA_WIDTH-1){1'b0}},
                            $signed(instr.rs_data) < $signed(instr.rt_data)};
         end
         SLTU: begin
            int_res.data = {{(DATA_WIDTH-1){1'b0}}, instr.rs_data < instr.rt_data};
         end
         BEQ: begin
            int_res.is_branch    = 1'b1;
            int_res.branch_taken = (instr.rs_data == instr.rt_data);
         end
         default: ;
      endcase
   end

   // A result request only comes from a busy unit
   assert property (@(posedge clk) disable iff (reset)
      (state == IDLE) |-> !int_res_req);

endmodule

`default_nettype wire

//--- design/cla_32.sv
`timescale 1ns/1ps
`default_nettype none

module cla_32
   import exec_pkg::*;
(
   input  logic [DATA_WIDTH-1:0] a_in,
   input  logic [DATA_WIDTH-1:0] b_in,
   input  logic                  carry_in,
   output logic [DATA_WIDTH-1:0] sum,
   output logic                  carry_out,
   output logic                  overflow
);

   localparam int GROUPS = DATA_WIDTH / 4;

   logic [DATA_WIDTH-1:0] gen;
   logic [DATA_WIDTH-1:0] prop;
   logic [GROUPS-1:0]     grp_gen;
   logic [GROUPS-1:0]     grp_prop;
   logic [GROUPS:0]       grp_carry;
   logic [DATA_WIDTH-1:0] carry;

   assign gen  = a_in & b_in;
   assign prop = a_in ^ b_in;

   // Group generate and propagate, 4 bits each
   always_comb begin
      for (int k = 0; k < GROUPS; k++) begin
         grp_gen[k] = gen[4*k+3]
                    | (prop[4*k+3] & gen[4*k+2])
                    | (prop[4*k+3] & prop[4*k+2] & gen[4*k+1])
                    | (prop[4*k+3] & prop[4*k+2] & prop[4*k+1] & gen[4*k]);
         grp_prop[k] = &prop[4*k +: 4];
      end
   end

   // Lookahead across the groups
   always_comb begin
      grp_carry[0] = carry_in;
      for (int k = 0; k < GROUPS; k++) begin
         grp_carry[k+1] = grp_gen[k] | (grp_prop[k] & grp_carry[k]);
      end
   end

   // Bit carries inside a group start from its group carry
   always_comb begin
      for (int k = 0; k < GROUPS; k++) begin
         carry[4*k]   = grp_carry[k];
         carry[4*k+1] = gen[4*k]   | (prop[4*k]   & carry[4*k]);
         carry[4*k+2] = gen[4*k+1] | (prop[4*k+1] & carry[4*k+1]);
         carry[4*k+3] = gen[4*k+2] | (prop[4*k+2] & carry[4*k+2]);
      end
   end

   assign sum       = prop ^ carry;
   assign carry_out = grp_carry[GROUPS];
   assign overflow  = carry[DATA_WIDTH-1] ^ grp_carry[GROUPS];

endmodule

`default_nettype wire

//--- design/exec_pkg.sv
`default_nettype none

package exec_pkg;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Widths
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   localparam int DATA_WIDTH = 32;
   localparam int TAG_WIDTH  = 6;

   // Opcodes seen by the back end
   typedef enum logic [3:0] {
      ADD  = 4'd0,
      ADDU = 4'd1,
      SUB  = 4'd2,
      SUBU = 4'd3,
      AND  = 4'd4,
      OR   = 4'd5,
      NOR  = 4'd6,
      SLT  = 4'd7,
      SLTU = 4'd8,
      BEQ  = 4'd9,
      MULT = 4'd10
   } exec_op_e;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Bus payloads
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // Issued instruction, 74 bits
   typedef struct packed {
      exec_op_e              op;
      logic [DATA_WIDTH-1:0] rs_data;
      logic [DATA_WIDTH-1:0] rt_data;
      logic [TAG_WIDTH-1:0]  rd_tag;
   } exec_instr_t;

   // Unit result, 42 bits
   typedef struct packed {
      logic [DATA_WIDTH-1:0] data;
      logic [TAG_WIDTH-1:0]  rd_tag;
      logic                  carry;
      logic                  overflow;
      logic                  is_branch;
      logic                  branch_taken;
   } exec_result_t;

   // Broadcast bus, one valid cycle per result
   typedef struct packed {
      logic         valid;
      exec_result_t result;
   } cdb_t;

endpackage

`default_nettype wire
